// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decoder.sv
  - hdl/rv_alu.sv
  - hdl/rv_regfile.sv
  - hdl/rv_sequencer.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - dv/rv_checker.sv
      - dv/tb_rv_core.sv

// File: dv/rv_checker.sv
module rv_checker (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          mem_valid,
    input  logic          mem_instr,
    input  logic          mem_ready,
    input  rv_pkg::word_t mem_addr,
    input  rv_pkg::word_t mem_wdata,
    input  logic [3:0]    mem_wstrb,
    input  logic          halted
);
    import rv_pkg::*;

    word_t exp_addr [$];
    word_t exp_data [$];
    word_t halt_addr    = '0;
    word_t last_fetch   = '0;
    int    stores_seen  = 0;
    int    mismatches   = 0;
    int    other_errors = 0;
    logic  halt_seen    = 1'b0;
    logic  halt_fault   = 1'b0;     // report a bad halt only once

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic expect_halt(input word_t addr);
        halt_addr = addr;
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    // one completed write on the bus
    task automatic check_store();
        if (stores_seen >= exp_addr.size()) begin
            report_failure($sformatf("unexpected extra store to address %h", mem_addr));
        end else begin
            compare($sformatf("mem_addr (store %0d)", stores_seen),
                    exp_addr[stores_seen], mem_addr);
            compare($sformatf("mem_wdata (store %0d)", stores_seen),
                    exp_data[stores_seen], mem_wdata);
            compare("mem_wstrb", 32'h0000_000f, {28'd0, mem_wstrb});
        end
        stores_seen++;
    endtask

    // --------------------------------------------------
    // bus monitor at mid-cycle where everything has settled
    // --------------------------------------------------
    always @(negedge clk) begin
        if (!reset_n) begin
            if (mem_wstrb !== 4'b0000 || halted !== 1'b0) begin
                report_failure("mem_wstrb or halted active during reset");
            end
        end else begin
            if (mem_valid && mem_ready) begin      // completes on the next edge
                if (mem_instr) begin
                    last_fetch = mem_addr;
                end else if (mem_wstrb != 4'b0000) begin
                    check_store();
                end
            end
            if (halted) begin
                halt_seen = 1'b1;
            end
            if (halt_seen && !halt_fault && (mem_valid || !halted)) begin
                halt_fault = 1'b1;
                report_failure("bus activity or halted dropped after the halt");
            end
        end
    end

    task automatic final_check();
        if (!halt_seen) begin
            report_failure("core never raised halted");
        end else begin
            compare("mem_addr (last fetch before halt)", halt_addr, last_fetch);
        end
        if (stores_seen < exp_addr.size()) begin
            report_failure($sformatf("too few stores, %0d of %0d seen",
                                     stores_seen, exp_addr.size()));
        end
        $display("checks done: %0d stores seen, %0d mismatches, %0d other errors",
                 stores_seen, mismatches, other_errors);
    endtask

    function automatic int total_errors();
        return mismatches + other_errors;
    endfunction

endmodule

// File: dv/tb_rv_core.sv
module tb_rv_core;
    import rv_pkg::*;

    localparam word_t RESET_PC  = 32'h0000_0100;
    localparam word_t DATA_BASE = 32'h0000_0400;  // store slots
    localparam int    MEM_WORDS = 512;
    localparam int    ALU_CASES = 10;
    localparam word_t OPA       = 32'hffff_ffec;  // -20 in x1
    localparam word_t OPB       = 32'h0000_0003;  // 3 in x2 and x10
    localparam word_t MARK_T    = 32'h0000_01a1;  // x8, taken path
    localparam word_t MARK_N    = 32'h0000_02b2;  // x9, fall-through path

    // RV32I major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    logic       clk;
    logic       reset_n;
    logic       mem_valid;
    logic       mem_instr;
    logic       mem_ready;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic [3:0] mem_wstrb;
    word_t      mem_rdata;
    logic       halted;

    word_t mem [MEM_WORDS];
    word_t prog [$];
    word_t store_addr;
    word_t lfsr = 32'h9c13_a3d2;
    int    wait_left;

    // alu table: funct3, alternate bit, immediate for the I form
    logic [2:0]  alu_f3  [ALU_CASES] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic        alu_alt [ALU_CASES] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                         1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    logic [11:0] alu_imm [ALU_CASES] = '{12'h007, 12'h7ff, 12'h004, 12'h005, 12'hfff,
                                         12'h0f0, 12'h004, 12'h01f, 12'h555, 12'h7f0};
    logic [2:0]  br_f3   [6]         = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    rv_core #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_valid (mem_valid),
        .mem_instr (mem_instr),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    rv_checker u_checker (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_valid (mem_valid),
        .mem_instr (mem_instr),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    // --------------------------------------------------
    // instruction encoders
    // --------------------------------------------------
    function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // --------------------------------------------------
    // reference rules
    // --------------------------------------------------
    function automatic logic signed_less(input word_t x, input word_t y);
        return (x[31] != y[31]) ? x[31] : (x < y);    // differing signs decide alone
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t x, input word_t y);
        word_t r;
        case (f3)
            3'd0:    r = alt ? x - y : x + y;
            3'd1:    r = x << y[4:0];
            3'd2:    r = {31'd0, signed_less(x, y)};
            3'd3:    r = {31'd0, x < y};
            3'd4:    r = x ^ y;
            3'd5:    r = (x >> y[4:0]) | ((alt && x[31]) ? ~(32'hffff_ffff >> y[4:0]) : 32'd0);
            3'd6:    r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t x, input word_t y);
        case (f3)
            3'd0:    return x == y;
            3'd1:    return x != y;
            3'd4:    return signed_less(x, y);
            3'd5:    return !signed_less(x, y);
            3'd6:    return x < y;
            default: return !(x < y);
        endcase
    endfunction

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic random_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int ready_delay();
        logic [1:0] d;
        d[0] = random_bit();
        d[1] = random_bit();
        return int'(d);
    endfunction

    // --------------------------------------------------
    // program assembly
    // --------------------------------------------------
    function automatic word_t here();
        return RESET_PC + 32'(prog.size()) * 4;
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic store_and_expect(input logic [4:0] rs, input word_t value);
        emit(s_type(store_addr[11:0], rs, 5'd0));
        u_checker.expect_store(store_addr, value);
        store_addr = store_addr + 4;
    endtask

    task automatic build_program();
        int          i;
        int          j;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        word_t       operand;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        word_t       v1;
        word_t       v2;
        word_t       pc_mark;
        word_t       load_from;

        emit(i_type(12'hfec, 5'd0, 3'd0, 5'd1, OP_I));
        emit(i_type(OPB[11:0], 5'd0, 3'd0, 5'd2, OP_I));
        emit(i_type(OPB[11:0], 5'd0, 3'd0, 5'd10, OP_I));
        emit(i_type(MARK_T[11:0], 5'd0, 3'd0, 5'd8, OP_I));
        emit(i_type(MARK_N[11:0], 5'd0, 3'd0, 5'd9, OP_I));

        // register form into x3 and immediate form into x4
        for (i = 0; i < ALU_CASES; i++) begin
            f3  = alu_f3[i];
            alt = alu_alt[i];
            emit(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
            store_and_expect(5'd3, alu_ref(f3, alt, OPA, OPB));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm12   = {1'b0, alt, 5'd0, alu_imm[i][4:0]};
                operand = {27'd0, alu_imm[i][4:0]};
            end else begin
                imm12   = alu_imm[i];
                operand = {{20{imm12[11]}}, imm12};
                alt     = 1'b0;     // no subi
            end
            emit(i_type(imm12, 5'd1, f3, 5'd4, OP_I));
            store_and_expect(5'd4, alu_ref(f3, alt, OPA, operand));
        end

        emit(u_type(20'habcde, 5'd5, OP_LUI));
        store_and_expect(5'd5, {20'habcde, 12'h000});
        pc_mark = here();
        emit(u_type(20'h00012, 5'd6, OP_AUIPC));
        store_and_expect(5'd6, {20'h00012, 12'h000} + pc_mark);

        // store, reload into x7, store again; then x0
        load_from = store_addr;
        store_and_expect(5'd1, OPA);
        emit(i_type(load_from[11:0], 5'd0, 3'b010, 5'd7, OP_LOAD));
        store_and_expect(5'd7, OPA);
        store_and_expect(5'd0, 32'd0);

        // each branch against (x1,x2), (x2,x1) and (x2,x10)
        for (i = 0; i < 6; i++) begin
            for (j = 0; j < 3; j++) begin
                rs1 = (j == 0) ? 5'd1 : 5'd2;
                rs2 = (j == 0) ? 5'd2 : ((j == 1) ? 5'd1 : 5'd10);
                v1  = (rs1 == 5'd1) ? OPA : OPB;
                v2  = (rs2 == 5'd1) ? OPA : OPB;
                emit(b_type(13'd12, rs2, rs1, br_f3[i]));
                emit(s_type(store_addr[11:0], 5'd9, 5'd0));
                emit(j_type(21'd8, 5'd0));
                emit(s_type(store_addr[11:0], 5'd8, 5'd0));     // branch target
                u_checker.expect_store(store_addr, branch_ref(br_f3[i], v1, v2) ? MARK_T : MARK_N);
                store_addr = store_addr + 4;
            end
        end

        pc_mark = here();
        emit(j_type(21'd8, 5'd11));
        emit(32'h0000_0000);        // skipped
        store_and_expect(5'd11, pc_mark + 4);

        pc_mark = here();
        emit(u_type(20'd0, 5'd12, OP_AUIPC));
        emit(i_type(12'd17, 5'd12, 3'd0, 5'd13, OP_JALR));     // odd target that lands at +16
        emit(32'h0000_0000);
        emit(32'h0000_0000);
        store_and_expect(5'd13, pc_mark + 8);

        u_checker.expect_halt(here());
        emit(32'hffff_ffff);
    endtask

    // --------------------------------------------------
    // memory model driving just after each rising edge
    // --------------------------------------------------
    always @(posedge clk) begin : memory_model
        int   b;
        logic in_reset;
        in_reset = !reset_n;    // reset as the core saw it at this edge
        #1;
        if (in_reset || !mem_valid) begin
            mem_ready = 1'b0;
            mem_rdata = '0;
        end else if (wait_left > 0) begin
            wait_left = wait_left - 1;
            mem_ready = 1'b0;
            mem_rdata = '0;
        end else begin
            mem_ready = 1'b1;
            mem_rdata = mem[mem_addr[10:2]];
            for (b = 0; b < 4; b++) begin
                if (mem_wstrb[b]) begin
                    mem[mem_addr[10:2]][8*b +: 8] = mem_wdata[8*b +: 8];
                end
            end
            wait_left = ready_delay();  // for the next request
        end
    end

    initial begin : main
        int i;
        int cycles;
        int limit;
        clk        = 1'b0;
        reset_n    = 1'b0;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        store_addr = DATA_BASE;
        wait_left  = ready_delay();
        // low bits 00 never form a valid opcode
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'ha5a5_0000 ^ (32'(i) << 2);
        end
        build_program();
        for (i = 0; i < prog.size(); i++) begin
            mem[(RESET_PC >> 2) + i] = prog[i];
        end
        limit = prog.size() * 4 * 4 + 200;

        repeat (10) @(posedge clk);
        #1 reset_n = 1'b1;

        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            u_checker.report_failure($sformatf("timeout, no halt within %0d cycles", limit));
        end else begin
            repeat (20) @(negedge clk);     // bus must stay idle
        end

        u_checker.final_check();
        if (u_checker.total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: hdl/rv_alu.sv
module rv_alu (
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   imm,
    input  logic [1:0]      alu_in1_sel,
    input  logic            alu_in2_sel,
    input  rv_pkg::alu_op_t alu_op,
    input  logic [2:0]      funct3,
    output rv_pkg::word_t   alu_result,
    output logic            branch_taken
);
    import rv_pkg::*;

    word_t      in1;
    word_t      in2;
    logic [4:0] shamt;

    // operand muxes
    always_comb begin
        case (alu_in1_sel)
            IN1_ZERO: in1 = '0;
            IN1_RS1:  in1 = rs1_data;
            IN1_PC:   in1 = pc;
            default:  in1 = '0;
        endcase
    end

    assign in2   = (alu_in2_sel == IN2_RS2) ? rs2_data : imm;
    assign shamt = in2[4:0];    // shifts use the low five bits

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = in1 + in2;
            alu_sub:  alu_result = in1 - in2;
            alu_sll:  alu_result = in1 << shamt;
            alu_slt:  alu_result = {31'b0, $signed(in1) < $signed(in2)};
            alu_sltu: alu_result = {31'b0, in1 < in2};
            alu_xor:  alu_result = in1 ^ in2;
            alu_srl:  alu_result = in1 >> shamt;
            alu_sra:  alu_result = $signed(in1) >>> shamt;
            alu_or:   alu_result = in1 | in2;
            alu_and:  alu_result = in1 & in2;
            default:  alu_result = '0;
        endcase
    end

    // --------------------------------------------------
    // branch condition straight from the register reads
    // --------------------------------------------------
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);                    // beq
            3'b001:  branch_taken = (rs1_data != rs2_data);                    // bne
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));   // blt
            3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));  // bge
            3'b110:  branch_taken = (rs1_data < rs2_data);                     // bltu
            3'b111:  branch_taken = (rs1_data >= rs2_data);                    // bgeu
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: hdl/rv_core.sv
module rv_core #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
    input  logic          clk,
    input  logic          reset_n,
    output logic          mem_valid,
    output logic          mem_instr,
    input  logic          mem_ready,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic [3:0]    mem_wstrb,
    input  rv_pkg::word_t mem_rdata,
    output logic          halted
);
    import rv_pkg::*;

    // --------------------------------------------------
    // internal wires
    // --------------------------------------------------
    word_t      instr;
    word_t      pc;
    word_t      imm;
    word_t      alu_result;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      rd_data;
    reg_addr_t  rd_addr;
    alu_op_t    alu_op;
    logic [1:0] alu_in1_sel;
    logic       alu_in2_sel;
    logic       reg_write;
    logic       mem_write;
    logic       mem_to_reg;
    logic       branch;
    logic       jump;
    logic       jump_reg;
    logic       illegal;
    logic       branch_taken;
    logic       rd_we;

    rv_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_sequencer (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_valid    (mem_valid),
        .mem_instr    (mem_instr),
        .mem_ready    (mem_ready),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wstrb    (mem_wstrb),
        .mem_rdata    (mem_rdata),
        .mem_write    (mem_write),
        .mem_to_reg   (mem_to_reg),
        .reg_write    (reg_write),
        .branch       (branch),
        .jump         (jump),
        .jump_reg     (jump_reg),
        .illegal      (illegal),
        .imm          (imm),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .rs2_data     (rs2_data),
        .instr        (instr),
        .pc           (pc),
        .rd_we        (rd_we),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .halted       (halted)
    );

    rv_decoder u_decoder (
        .instr       (instr),
        .reg_write   (reg_write),
        .mem_write   (mem_write),
        .mem_to_reg  (mem_to_reg),
        .branch      (branch),
        .jump        (jump),
        .jump_reg    (jump_reg),
        .illegal     (illegal),
        .alu_in1_sel (alu_in1_sel),
        .alu_in2_sel (alu_in2_sel),
        .alu_op      (alu_op),
        .imm         (imm)
    );

    // source indices straight from the instruction register
    rv_regfile u_regfile (
        .clk      (clk),
        .reset_n  (reset_n),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .rd_addr  (rd_addr),
        .rd_we    (rd_we),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .imm          (imm),
        .alu_in1_sel  (alu_in1_sel),
        .alu_in2_sel  (alu_in2_sel),
        .alu_op       (alu_op),
        .funct3       (instr[14:12]),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

endmodule

// File: hdl/rv_decoder.sv
module rv_decoder (
    input  rv_pkg::word_t   instr,
    output logic            reg_write,
    output logic            mem_write,
    output logic            mem_to_reg,
    output logic            branch,
    output logic            jump,
    output logic            jump_reg,
    output logic            illegal,
    output logic [1:0]      alu_in1_sel,
    output logic            alu_in2_sel,
    output rv_pkg::alu_op_t alu_op,
    output rv_pkg::word_t   imm
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;        // instr[30] picks sub and sra
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    word_t      imm_sh;

    // funct3 plus the alternate bit to an alu operation
    function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt_bit);
        alu_op_t op_sel;
        case (f3)
            3'b000:  op_sel = alt_bit ? alu_sub : alu_add;
            3'b001:  op_sel = alu_sll;
            3'b010:  op_sel = alu_slt;
            3'b011:  op_sel = alu_sltu;
            3'b100:  op_sel = alu_xor;
            3'b101:  op_sel = alt_bit ? alu_sra : alu_srl;
            3'b110:  op_sel = alu_or;
            default: op_sel = alu_and;
        endcase
        return op_sel;
    endfunction

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    // --------------------------------------------------
    // immediates
    // --------------------------------------------------
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_sh = {27'b0, instr[24:20]};     // shamt only with funct7 stripped

    always_comb begin
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        jump_reg    = 1'b0;
        illegal     = 1'b0;
        alu_in1_sel = IN1_RS1;
        alu_in2_sel = IN2_IMM;
        alu_op      = alu_add;      // address calc by default
        imm         = imm_i;
        case (opcode)
            opc_op: begin
                reg_write   = 1'b1;
                alu_in2_sel = IN2_RS2;
                alu_op      = funct_to_alu(funct3, alt);
            end
            opc_op_imm: begin
                reg_write = 1'b1;
                alu_op    = funct_to_alu(funct3, (funct3 == 3'b101) && alt); // no subi
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm = imm_sh;
                end
            end
            opc_load: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
            end
            opc_store: begin
                mem_write = 1'b1;
                imm       = imm_s;
            end
            opc_branch: begin
                branch = 1'b1;
                imm    = imm_b;
            end
            opc_jal: begin
                reg_write   = 1'b1;
                jump        = 1'b1;
                alu_in1_sel = IN1_PC;
                imm         = imm_j;
            end
            opc_jalr: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                jump_reg  = 1'b1;   // target is rs1 + imm
            end
            opc_lui: begin
                reg_write   = 1'b1;
                alu_in1_sel = IN1_ZERO;
                imm         = imm_u;
            end
            opc_auipc: begin
                reg_write   = 1'b1;
                alu_in1_sel = IN1_PC;
                imm         = imm_u;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    // --------------------------------------------------
    // basic types
    // --------------------------------------------------
    typedef logic [31:0] word_t;        // data, address or instruction
    typedef logic [4:0]  reg_addr_t;    // x0 .. x31

    localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

    // --------------------------------------------------
    // instruction encodings
    // --------------------------------------------------
    // major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_t;

    // alu operation codes
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0001,
        alu_sll  = 4'b0010,
        alu_slt  = 4'b0011,
        alu_sltu = 4'b0100,
        alu_xor  = 4'b0101,
        alu_srl  = 4'b0110,
        alu_sra  = 4'b0111,
        alu_or   = 4'b1000,
        alu_and  = 4'b1001
    } alu_op_t;

    // first operand select
    localparam logic [1:0] IN1_ZERO = 2'd0;   // lui
    localparam logic [1:0] IN1_RS1  = 2'd1;
    localparam logic [1:0] IN1_PC   = 2'd2;   // auipc, jal

    // second operand select
    localparam logic IN2_IMM = 1'b0;
    localparam logic IN2_RS2 = 1'b1;

    // --------------------------------------------------
    // sequencer stages
    // --------------------------------------------------
    typedef enum logic [2:0] {
        st_fetch,
        st_execute,
        st_memory,      // lw / sw only
        st_writeback,
        st_halt         // entered on an unknown opcode
    } stage_t;

endpackage

// File: hdl/rv_regfile.sv
module rv_regfile (
    input  logic              clk,
    input  logic              reset_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  logic              rd_we,
    input  rv_pkg::word_t     rd_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: hdl/rv_sequencer.sv
module rv_sequencer #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
    input  logic              clk,
    input  logic              reset_n,
    // memory port
    output logic              mem_valid,
    output logic              mem_instr,
    input  logic              mem_ready,
    output rv_pkg::word_t     mem_addr,
    output rv_pkg::word_t     mem_wdata,
    output logic [3:0]        mem_wstrb,
    input  rv_pkg::word_t     mem_rdata,
    // from decoder and datapath
    input  logic              mem_write,
    input  logic              mem_to_reg,
    input  logic              reg_write,
    input  logic              branch,
    input  logic              jump,
    input  logic              jump_reg,
    input  logic              illegal,
    input  rv_pkg::word_t     imm,
    input  rv_pkg::word_t     alu_result,
    input  logic              branch_taken,
    input  rv_pkg::word_t     rs2_data,
    // to decoder, alu and register file
    output rv_pkg::word_t     instr,
    output rv_pkg::word_t     pc,
    output logic              rd_we,
    output rv_pkg::reg_addr_t rd_addr,
    output rv_pkg::word_t     rd_data,
    output logic              halted
);
    import rv_pkg::*;

    stage_t state;
    word_t  load_data;
    word_t  pc_plus4;
    word_t  next_pc;
    logic   fire;       // handshake completes this edge

    assign fire = mem_valid && mem_ready;

    // --------------------------------------------------
    // stage FSM and pc
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= st_fetch;
            pc    <= RESET_PC;
        end else begin
            case (state)
                st_fetch: if (fire) state <= st_execute;
                st_execute: begin
                    if (illegal) begin
                        state <= st_halt;
                    end else if (mem_write || mem_to_reg) begin
                        state <= st_memory;
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_memory: if (fire) state <= st_writeback;
                st_writeback: begin
                    state <= st_fetch;
                    pc    <= next_pc;
                end
                st_halt: state <= st_halt;  // wait for reset
                default: state <= st_halt;
            endcase
        end
    end

    // instruction and load data captured at completion
    always_ff @(posedge clk) begin
        if (state == st_fetch && fire) begin
            instr <= mem_rdata;
        end
        if (state == st_memory && fire && mem_to_reg) begin
            load_data <= mem_rdata;
        end
    end

    // --------------------------------------------------
    // memory port
    // --------------------------------------------------
    assign mem_valid = (state == st_fetch) || (state == st_memory);
    assign mem_instr = (state == st_fetch);
    assign mem_addr  = (state == st_fetch)  ? pc :
                       (state == st_memory) ? alu_result   // lw / sw address
                                            : '0;
    assign mem_wdata = (state == st_memory && mem_write) ? rs2_data : '0;
    assign mem_wstrb = (state == st_memory && mem_write) ? 4'b1111 : 4'b0000;

    // writeback
    assign pc_plus4 = pc + 32'd4;
    assign rd_we    = (state == st_writeback) && reg_write;
    assign rd_addr  = instr[11:7];

    always_comb begin
        if (mem_to_reg) begin
            rd_data = load_data;
        end else if (jump) begin
            rd_data = pc_plus4;     // link value
        end else begin
            rd_data = alu_result;
        end
    end

    always_comb begin
        if (jump_reg) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (jump || (branch && branch_taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign halted = (state == st_halt);

endmodule

// File: verilog.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_sequencer.sv
hdl/rv_core.sv
dv/rv_checker.sv
dv/tb_rv_core.sv
